/* Makefile */
# Verilator build and run for the uart loopback testbench

VERILATOR  = verilator
FLAGS      = --binary --timing --assert -Mdir obj_dir
LINT_FLAGS = --lint-only --timing --assert
TOP        = uart_loopback_tb
FILELIST   = all.f
SIM_ARGS   = +verilator+error+limit+1000
PASS_MSG   = RESULT: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# fails unless the pass line shows up in the output
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* all.f */
common/uart_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
hdl/loopback_ctrl.sv
hdl/uart_loopback_top.sv
verification/tb_clock_gen.sv
verification/uart_loopback_properties.sv
verification/uart_loopback_tb.sv

/* common/uart_pkg.sv */
/*
 * uart shared definitions
 * character types and 8N1 framing constants for the loopback subsystem
 */

package uart_pkg;

   // framing, 8N1
   localparam int DATA_BITS  = 8;
   localparam int FRAME_BITS = DATA_BITS + 2;  // start + data + stop

   localparam logic START_BIT  = 1'b0;
   localparam logic STOP_BIT   = 1'b1;
   localparam logic IDLE_LEVEL = 1'b1;         // line level between frames

   // one data byte on the wire
   typedef logic [DATA_BITS-1:0] uart_byte_t;

   // received character plus its framing flag
   typedef struct packed {
      uart_byte_t data;
      logic       frame_error;  // stop bit sampled low
   } rx_char_t;

endpackage

/* hdl/loopback_ctrl.sv */
/*
 * loopback controller
 * reads each received character, drops framing errors, echoes good ones
 */
`timescale 1ns/100ps

module loopback_ctrl (
   input  logic                 clk_50mhz,
   input  logic                 reset,
   input  logic                 rx_valid,
   input  uart_pkg::rx_char_t   rx_char,
   input  logic                 tx_busy,
   output logic                 rd,            // read pulse to rx
   output logic                 wr,            // write pulse to tx
   output uart_pkg::uart_byte_t tx_data,
   output logic                 echo_pending   // good byte held, not yet sent
);
   import uart_pkg::*;

   localparam logic recv_char = 1'b0;
   localparam logic send_char = 1'b1;

   logic       state_q;
   logic       rd_q;
   logic       wr_q;
   uart_byte_t tx_data_q;
   logic       take;     // new character to read this cycle

   // rx_valid stays up one cycle after rd, don't read twice
   assign take = (state_q == recv_char) && rx_valid && !rd_q;

   always_ff @(posedge clk_50mhz) begin
      if (reset) begin
         state_q <= recv_char;
         rd_q    <= 1'b0;
         wr_q    <= 1'b0;
      end else begin
         rd_q <= 1'b0;   // strobes last one cycle
         wr_q <= 1'b0;
         case (state_q)
            recv_char: begin
               if (take) begin
                  rd_q <= 1'b1;
                  if (!rx_char.frame_error) state_q <= send_char;  // bad ones dropped
               end
            end
            send_char: begin
               if (!tx_busy) begin   // wait out back-pressure
                  wr_q    <= 1'b1;
                  state_q <= recv_char;
               end
            end
            default: state_q <= recv_char;
         endcase
      end
   end

   // byte held until tx is free
   always_ff @(posedge clk_50mhz) begin
      if (take && !rx_char.frame_error) tx_data_q <= rx_char.data;
   end

   assign rd           = rd_q;
   assign wr           = wr_q;
   assign tx_data      = tx_data_q;
   assign echo_pending = (state_q == send_char);

endmodule

/* hdl/uart_loopback_top.sv */
/*
 * uart loopback top level
 * receiver, loopback controller and transmitter on one 50 MHz clock
 */
`timescale 1ns/100ps

module uart_loopback_top #(
   parameter int clk_freq = 50_000_000,
   parameter int baud     = 115_200
) (
   input  logic clk_50mhz,
   input  logic reset,
   input  logic rxd,            // serial in
   output logic txd,            // serial out, echo
   output logic echo_pending
);
   import uart_pkg::*;

   logic       rx_valid;
   rx_char_t   rx_char;
   logic       rd;
   logic       wr;
   uart_byte_t tx_data;
   logic       tx_busy;

   uart_rx #(
      .clk_freq (clk_freq),
      .baud     (baud)
   ) uart_rx_i (
      .clk_50mhz (clk_50mhz),
      .reset     (reset),
      .rxd       (rxd),
      .rd        (rd),
      .rx_valid  (rx_valid),
      .rx_char   (rx_char)
   );

   loopback_ctrl loopback_ctrl_i (
      .clk_50mhz    (clk_50mhz),
      .reset        (reset),
      .rx_valid     (rx_valid),
      .rx_char      (rx_char),
      .tx_busy      (tx_busy),
      .rd           (rd),
      .wr           (wr),
      .tx_data      (tx_data),
      .echo_pending (echo_pending)
   );

   uart_tx #(
      .clk_freq (clk_freq),
      .baud     (baud)
   ) uart_tx_i (
      .clk_50mhz (clk_50mhz),
      .reset     (reset),
      .wr        (wr),
      .tx_data   (tx_data),
      .txd       (txd),
      .tx_busy   (tx_busy)
   );

endmodule

/* uart/uart_rx.sv */
/*
 * uart receiver, 8N1
 * syncs rxd, finds the start bit, samples mid-bit, holds the character until rd
 */
`timescale 1ns/100ps

module uart_rx #(
   parameter int clk_freq = 50_000_000,
   parameter int baud     = 115_200
) (
   input  logic               clk_50mhz,
   input  logic               reset,
   input  logic               rxd,       // async serial in
   input  logic               rd,        // read strobe
   output logic               rx_valid,  // character waiting
   output uart_pkg::rx_char_t rx_char
);
   import uart_pkg::*;

   localparam int clks_per_bit = clk_freq / baud;
   localparam int half_bit     = clks_per_bit / 2;
   localparam int cnt_w        = $clog2(clks_per_bit);
   localparam int idx_w        = $clog2(DATA_BITS);

   // receive states
   localparam logic [1:0] st_idle  = 2'd0;
   localparam logic [1:0] st_start = 2'd1;
   localparam logic [1:0] st_data  = 2'd2;
   localparam logic [1:0] st_stop  = 2'd3;

   logic             rxd_meta;    // first sync flop
   logic             rxd_sync;    // safe to use
   logic             rxd_last;    // for edge detect
   logic [1:0]       state_q;
   logic [cnt_w-1:0] cnt_q;       // clocks into current bit
   logic [idx_w-1:0] idx_q;       // data bit number
   uart_byte_t       shreg_q;
   rx_char_t         rx_char_q;
   logic             rx_valid_q;
   logic             half_end;
   logic             bit_end;
   logic             start_edge;

   assign half_end   = (cnt_q == cnt_w'(half_bit - 1));
   assign bit_end    = (cnt_q == cnt_w'(clks_per_bit - 1));
   assign start_edge = rxd_last && !rxd_sync;   // falling edge on the line

   // two flop synchronizer, idles high so reset can't fake a start
   always_ff @(posedge clk_50mhz) begin
      if (reset) begin
         rxd_meta <= IDLE_LEVEL;
         rxd_sync <= IDLE_LEVEL;
         rxd_last <= IDLE_LEVEL;
      end else begin
         rxd_meta <= rxd;
         rxd_sync <= rxd_meta;
         rxd_last <= rxd_sync;
      end
   end

   // frame fsm
   always_ff @(posedge clk_50mhz) begin
      if (reset) begin
         state_q    <= st_idle;
         cnt_q      <= '0;
         idx_q      <= '0;
         rx_valid_q <= 1'b0;
      end else begin
         if (rd) rx_valid_q <= 1'b0;   // read clears, frame end below wins
         cnt_q <= cnt_q + 1'b1;
         case (state_q)
            st_idle: begin
               cnt_q <= '0;
               idx_q <= '0;
               if (start_edge) state_q <= st_start;
            end
            st_start: begin
               if (half_end) begin    // middle of start bit
                  cnt_q   <= '0;
                  state_q <= (rxd_sync == START_BIT) ? st_data : st_idle;  // glitch -> idle
               end
            end
            st_data: begin
               if (bit_end) begin
                  cnt_q <= '0;
                  idx_q <= idx_q + 1'b1;
                  if (idx_q == idx_w'(DATA_BITS - 1)) state_q <= st_stop;
               end
            end
            st_stop: begin
               if (bit_end) begin
                  rx_valid_q <= 1'b1;  // overrun just overwrites
                  state_q    <= st_idle;
               end
            end
            default: state_q <= st_idle;
         endcase
      end
   end

   // data path, lsb arrives first
   always_ff @(posedge clk_50mhz) begin
      if (state_q == st_data && bit_end)
         shreg_q <= {rxd_sync, shreg_q[DATA_BITS-1:1]};
      if (state_q == st_stop && bit_end) begin
         rx_char_q.data        <= shreg_q;
         rx_char_q.frame_error <= (rxd_sync != STOP_BIT);
      end
   end

   assign rx_valid = rx_valid_q;
   assign rx_char  = rx_char_q;

endmodule

/* uart/uart_tx.sv */
/*
 * uart transmitter, 8N1
 * loads a frame on wr and shifts it out lsb first, busy until stop bit ends
 */
`timescale 1ns/100ps

module uart_tx #(
   parameter int clk_freq = 50_000_000,
   parameter int baud     = 115_200
) (
   input  logic                 clk_50mhz,
   input  logic                 reset,
   input  logic                 wr,        // write strobe
   input  uart_pkg::uart_byte_t tx_data,
   output logic                 txd,       // serial out
   output logic                 tx_busy
);
   import uart_pkg::*;

   localparam int clks_per_bit = clk_freq / baud;
   localparam int cnt_w        = $clog2(clks_per_bit);
   localparam int idx_w        = $clog2(FRAME_BITS);

   logic [FRAME_BITS-1:0] frame_q;   // bit 0 is on the wire
   logic [cnt_w-1:0]      cnt_q;
   logic [idx_w-1:0]      idx_q;     // bits sent so far
   logic                  busy_q;
   logic                  bit_end;

   assign bit_end = (cnt_q == cnt_w'(clks_per_bit - 1));

   always_ff @(posedge clk_50mhz) begin
      if (reset) begin
         frame_q <= {FRAME_BITS{IDLE_LEVEL}};  // line idles high
         cnt_q   <= '0;
         idx_q   <= '0;
         busy_q  <= 1'b0;
      end else if (!busy_q) begin
         cnt_q <= '0;
         idx_q <= '0;
         if (wr) begin
            frame_q <= {STOP_BIT, tx_data, START_BIT};
            busy_q  <= 1'b1;
         end
      end else if (bit_end) begin
         cnt_q   <= '0;
         frame_q <= {IDLE_LEVEL, frame_q[FRAME_BITS-1:1]};  // back-fill idle
         idx_q   <= idx_q + 1'b1;
         if (idx_q == idx_w'(FRAME_BITS - 1))
            busy_q <= 1'b0;   // stop bit done
      end else begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   // straight from a flop, no glitches on the line
   assign txd     = frame_q[0];
   assign tx_busy = busy_q;

endmodule

/* verification/tb_clock_gen.sv */
/*
 * testbench clock and reset source
 * free running 50 MHz clock, reset held high for the first few cycles
 */
`timescale 1ns/100ps

module tb_clock_gen #(
   parameter int period_ns    = 20,
   parameter int reset_cycles = 3
) (
   output logic clk_50mhz,
   output logic reset
);

   initial begin
      clk_50mhz = 1'b0;
      forever #(period_ns / 2) clk_50mhz = ~clk_50mhz;
   end

   // sync reset, released just after an edge
   initial begin
      reset = 1'b1;
      repeat (reset_cycles) @(posedge clk_50mhz);
      #1 reset = 1'b0;
   end

endmodule

/* verification/uart_loopback_properties.sv */
/*
 * loopback strobe properties
 * concurrent checks on the rx, controller and tx handshakes inside the top
 */
`timescale 1ns/100ps

module uart_loopback_properties (
   input logic clk_50mhz,
   input logic reset,
   input logic rd,
   input logic rx_valid,
   input logic wr,
   input logic tx_busy,
   input logic txd
);

   int fail_count = 0;   // tallied by the testbench

   // read only when a character waits
   rd_needs_valid: assert property (@(posedge clk_50mhz) disable iff (reset)
      rd |-> rx_valid)
      else begin
         fail_count++;
         $error("rd pulsed while rx_valid was low");
      end

   // no write into a busy transmitter
   wr_needs_idle: assert property (@(posedge clk_50mhz) disable iff (reset)
      wr |-> !tx_busy)
      else begin
         fail_count++;
         $error("wr pulsed while tx_busy was high");
      end

   wr_sets_busy: assert property (@(posedge clk_50mhz) disable iff (reset)
      wr |=> tx_busy)
      else begin
         fail_count++;
         $error("tx_busy did not rise after wr");
      end

   // line idles high between frames
   idle_line_high: assert property (@(posedge clk_50mhz) disable iff (reset)
      !tx_busy |-> txd)
      else begin
         fail_count++;
         $error("txd low while transmitter idle");
      end

endmodule

bind uart_loopback_top uart_loopback_properties uart_loopback_properties_i (
   .clk_50mhz (clk_50mhz),
   .reset     (reset),
   .rd        (rd),
   .rx_valid  (rx_valid),
   .wr        (wr),
   .tx_busy   (tx_busy),
   .txd       (txd)
);

/* verification/uart_loopback_tb.sv */
/*
 * uart loopback testbench
 * drives 8N1 frames into rxd, decodes the echo on txd and checks it in order
 */
`timescale 1ns/100ps

module uart_loopback_tb;
   import uart_pkg::*;

   localparam int clk_freq     = 50_000_000;
   localparam int baud         = 5_000_000;
   localparam int cpb          = clk_freq / baud;   // 10 clocks per bit
   localparam int echo_timeout = 40 * cpb;          // clocks to wait for a start bit

   logic       clk_50mhz;
   logic       reset;
   logic       rxd = 1'b1;   // line idle from time 0
   logic       txd;
   logic       echo_pending;
   uart_byte_t expected_q[$];  // bytes still owed on txd
   uart_byte_t rand_byte;
   integer     seed = 32'h227013e7;
   int         value_errors = 0;
   int         timeout_errors = 0;
   int         prop_errors;
   int         waited;

   tb_clock_gen clock_gen_i (
      .clk_50mhz (clk_50mhz),
      .reset     (reset)
   );

   uart_loopback_top #(
      .clk_freq (clk_freq),
      .baud     (baud)
   ) uart_loopback_top_i (
      .clk_50mhz    (clk_50mhz),
      .reset        (reset),
      .rxd          (rxd),
      .txd          (txd),
      .echo_pending (echo_pending)
   );

   // one bit on rxd, caller sits 1 ns past a rising edge
   task automatic hold_bit(input logic level);
      rxd = level;
      repeat (cpb) @(posedge clk_50mhz);
      #1;
   endtask

   task automatic send_frame(input uart_byte_t data, input logic bad_stop);
      hold_bit(1'b0);                   // start
      for (int i = 0; i < DATA_BITS; i++)
         hold_bit(data[i]);             // lsb first
      hold_bit(!bad_stop);
      if (bad_stop) hold_bit(1'b1);     // needs a high bit before the next falling edge
   endtask

   // decode one frame on txd, sampled on falling clock edges
   task automatic receive_echo(output uart_byte_t data, output logic got,
                               output logic stop_ok, output logic pend_seen);
      int wait_cnt;
      got       = 1'b0;
      stop_ok   = 1'b0;
      pend_seen = 1'b0;
      data      = '0;
      wait_cnt  = 0;
      @(negedge clk_50mhz);
      while (txd !== 1'b0 && wait_cnt < echo_timeout) begin
         pend_seen = pend_seen | (echo_pending === 1'b1);  // sticky till start bit
         @(negedge clk_50mhz);
         wait_cnt++;
      end
      if (txd === 1'b0) begin
         repeat (cpb / 2 - 1) @(negedge clk_50mhz);   // middle of start bit
         for (int i = 0; i < DATA_BITS; i++) begin
            repeat (cpb) @(negedge clk_50mhz);
            data[i] = txd;
         end
         repeat (cpb) @(negedge clk_50mhz);
         stop_ok = (txd === 1'b1);
         got     = 1'b1;
      end
   endtask

   task automatic check_echo();
      uart_byte_t data;
      uart_byte_t exp;
      logic       got;
      logic       stop_ok;
      logic       pend_seen;
      receive_echo(data, got, stop_ok, pend_seen);
      if (!got) begin
         timeout_errors++;
         $display("No echo arrived on txd within %0d clocks, at time %0t", echo_timeout,
                  $time);
         if (expected_q.size() > 0) exp = expected_q.pop_front();  // keep order
      end else begin
         assert (expected_q.size() > 0) else begin
            value_errors++;
            $display("FAIL %0t: unexpected echo %h", $time, data);
         end
         if (expected_q.size() > 0) begin
            exp = expected_q.pop_front();
            assert (data === exp) else begin
               value_errors++;
               $display("FAIL %0t: echo expected %h, got %h", $time, exp, data);
            end
         end
         assert (stop_ok) else begin
            value_errors++;
            $display("FAIL %0t: echo stop bit low", $time);
         end
         assert (pend_seen) else begin
            value_errors++;
            $display("FAIL %0t: echo_pending never high before echo", $time);
         end
      end
   endtask

   // quiet line, nothing pending
   task automatic check_idle(input int bits);
      for (int i = 0; i < bits * cpb; i++) begin
         @(negedge clk_50mhz);
         assert (txd === 1'b1 && echo_pending === 1'b0) else begin
            value_errors++;
            $display("FAIL %0t: not idle, txd=%b echo_pending=%b", $time, txd, echo_pending);
         end
      end
   endtask

   initial begin
      waited = 0;
      while (reset !== 1'b0 && waited < 100) begin
         @(posedge clk_50mhz);
         waited++;
      end
      if (reset !== 1'b0) begin
         timeout_errors++;
         $display("Reset was never released");
      end

      check_idle(20);   // after reset

      // single byte
      expected_q.push_back(8'h55);
      @(posedge clk_50mhz);
      #1;
      fork
         send_frame(8'h55, 1'b0);
         check_echo();
      join
      check_idle(3);

      // back to back random bytes, tx back-pressure
      @(posedge clk_50mhz);
      #1;
      fork
         begin
            repeat (8) begin
               rand_byte = 8'($random(seed));
               expected_q.push_back(rand_byte);
               send_frame(rand_byte, 1'b0);
            end
         end
         begin
            repeat (8) check_echo();
         end
      join
      check_idle(3);

      // framing error dropped, next good byte still echoed
      expected_q.push_back(8'h3c);
      @(posedge clk_50mhz);
      #1;
      fork
         begin
            send_frame(8'ha3, 1'b1);
            send_frame(8'h3c, 1'b0);
         end
         check_echo();
      join
      check_idle(12);   // bad byte must not show up late

      assert (expected_q.size() == 0) else begin
         value_errors++;
         $display("FAIL %0t: %0d echoes never checked", $time, expected_q.size());
      end

      prop_errors = uart_loopback_top_i.uart_loopback_properties_i.fail_count;
      $display("errors: %0d value, %0d timeout, %0d property", value_errors,
               timeout_errors, prop_errors);
      if (value_errors == 0 && timeout_errors == 0 && prop_errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule
